// File: flist.f
isa_pkg.sv
pipe_pkg.sv
id_ex_if.sv
ex_mem_if.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
mips_pipeline_top.sv
tb_mips_pipeline.sv

// File: Bender.yml
package:
  name: mips_pipeline

sources:
  - files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - id_ex_if.sv
      - ex_mem_if.sv
      - fetch_stage.sv
      - register_file.sv
      - decode_stage.sv
      - hazard_unit.sv
      - execute_stage.sv
      - memory_stage.sv
      - mips_pipeline_top.sv
  - target: test
    files:
      - tb_mips_pipeline.sv

// File: tb_mips_pipeline.sv
`timescale 1ns/1ps

module tb_mips_pipeline;

    localparam int DMEM_WORDS      = 64;
    localparam int PROG_LEN        = 200;
    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int TAIL_CYCLES     = 8;
    localparam int WATCHDOG_CYCLES = 3 * PROG_LEN + 50;

    logic              clk;
    logic              rst_n;
    isa_pkg::word_t    imem_addr;
    isa_pkg::word_t    imem_data;
    logic              wb_we;
    isa_pkg::reg_idx_t wb_addr;
    isa_pkg::word_t    wb_data;

    integer            seed;
    int                wb_count;
    int                taken_count;
    int                stall_count;

    isa_pkg::word_t    prog [PROG_LEN];
    isa_pkg::word_t    arch_regs [isa_pkg::NUM_REGS];
    isa_pkg::word_t    rf_view [isa_pkg::NUM_REGS];
    isa_pkg::word_t    dmem_model [DMEM_WORDS];
    isa_pkg::reg_idx_t exp_addr_q [$];
    isa_pkg::word_t    exp_data_q [$];

    // Model copies of the EX and MEM slots ahead of decode
    logic              ex_we;
    logic              ex_load;
    isa_pkg::reg_idx_t ex_addr;
    isa_pkg::reg_idx_t ex_rt;
    isa_pkg::word_t    ex_data;
    logic              mem_we;
    isa_pkg::reg_idx_t mem_addr;
    isa_pkg::word_t    mem_data;

    mips_pipeline_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_we     (wb_we),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the program did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_wb_addr(input isa_pkg::reg_idx_t got, input isa_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("FAILED wb_addr: got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_wb_data(input isa_pkg::word_t got, input isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED wb_data: got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_wb_we(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED wb_we: got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_imem_addr(input isa_pkg::word_t got, input isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED imem_addr: got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Program generation
    ////////////////////////////////////////////////////////////
    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic isa_pkg::word_t encode_i(input logic [5:0] op, input int unsigned rs,
                                                input int unsigned rt, input int unsigned imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic build_program();
        logic [5:0]  fn;
        int unsigned off;
        for (int k = 0; k < PROG_LEN; k++) begin
            case (rand_below(8))
                4: prog[k] = encode_i(isa_pkg::OP_LW, 0, rand_below(8), rand_below(16) * 4);
                5: prog[k] = encode_i(isa_pkg::OP_SW, 0, rand_below(8), rand_below(16) * 4);
                6: begin
                    off = rand_below(4);
                    // Keep the target inside the program
                    if (k + 1 + off > PROG_LEN) begin
                        off = PROG_LEN - k - 1;
                    end
                    prog[k] = encode_i(isa_pkg::OP_BEQ, rand_below(8), rand_below(8), off);
                end
                default: begin
                    case (rand_below(4))
                        0:       fn = isa_pkg::FN_ADD;
                        1:       fn = isa_pkg::FN_SUB;
                        2:       fn = isa_pkg::FN_AND;
                        default: fn = isa_pkg::FN_OR;
                    endcase
                    prog[k] = encode_i(isa_pkg::OP_RTYPE, rand_below(8), rand_below(8),
                                       (rand_below(8) << 11) | fn);
                end
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    // One decode cycle passes; the MEM slot retires into the register file
    task automatic advance_slot(input logic we, input isa_pkg::reg_idx_t addr,
                                input isa_pkg::word_t data, input logic is_load,
                                input isa_pkg::reg_idx_t rt);
        if (mem_we && mem_addr != 5'd0) begin
            rf_view[mem_addr] = mem_data;
        end
        mem_we   = ex_we;
        mem_addr = ex_addr;
        mem_data = ex_data;
        ex_we    = we;
        ex_addr  = addr;
        ex_data  = data;
        ex_load  = is_load;
        ex_rt    = rt;
    endtask

    task automatic record_write(input isa_pkg::reg_idx_t addr, input isa_pkg::word_t data);
        arch_regs[addr] = data;
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic run_model();
        int unsigned       pc_idx;
        isa_pkg::word_t    instr;
        logic [5:0]        op;
        logic [5:0]        fn;
        isa_pkg::reg_idx_t rs;
        isa_pkg::reg_idx_t rt;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    imm;
        isa_pkg::word_t    a;
        isa_pkg::word_t    b;
        isa_pkg::word_t    val;
        logic              we;
        int unsigned       idx;
        pc_idx = 0;
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            arch_regs[i] = '0;
            rf_view[i]   = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem_model[i] = '0;
        end
        {ex_we, ex_load, ex_addr, ex_rt, ex_data} = '0;
        {mem_we, mem_addr, mem_data} = '0;
        while (pc_idx < PROG_LEN) begin
            instr = prog[pc_idx];
            op    = instr[isa_pkg::OP_MSB:isa_pkg::OP_LSB];
            fn    = instr[isa_pkg::FN_MSB:isa_pkg::FN_LSB];
            rs    = instr[isa_pkg::RS_MSB:isa_pkg::RS_LSB];
            rt    = instr[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
            rd    = instr[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
            imm   = {{16{instr[isa_pkg::IMM_MSB]}}, instr[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB]};
            // Load-use hazard puts one bubble ahead of this instruction
            if (ex_load && ex_rt != 5'd0 && (ex_rt == rs || ex_rt == rt)) begin
                advance_slot(1'b0, '0, '0, 1'b0, '0);
                stall_count++;
            end
            pc_idx++;
            idx = ((arch_regs[rs] + imm) >> 2) % DMEM_WORDS;
            case (op)
                isa_pkg::OP_RTYPE: begin
                    a  = arch_regs[rs];
                    b  = arch_regs[rt];
                    we = (rd != 5'd0);
                    case (fn)
                        isa_pkg::FN_ADD: val = a + b;
                        isa_pkg::FN_SUB: val = a - b;
                        isa_pkg::FN_AND: val = a & b;
                        isa_pkg::FN_OR:  val = a | b;
                        default: begin
                            val = '0;
                            we  = 1'b0;
                        end
                    endcase
                    if (we) begin
                        record_write(rd, val);
                    end
                    advance_slot(we, rd, val, 1'b0, rt);
                end
                isa_pkg::OP_LW: begin
                    val = dmem_model[idx];
                    if (rt != 5'd0) begin
                        record_write(rt, val);
                    end
                    advance_slot(rt != 5'd0, rt, val, 1'b1, rt);
                end
                isa_pkg::OP_SW: begin
                    dmem_model[idx] = arch_regs[rt];
                    advance_slot(1'b0, '0, '0, 1'b0, rt);
                end
                isa_pkg::OP_BEQ: begin
                    // Comparator sees only the register file without forwarding
                    a = (rs == 5'd0) ? '0 : rf_view[rs];
                    b = (rt == 5'd0) ? '0 : rf_view[rt];
                    advance_slot(1'b0, '0, '0, 1'b0, rt);
                    if (a == b) begin
                        advance_slot(1'b0, '0, '0, 1'b0, '0);
                        pc_idx = pc_idx + int'(imm);
                        taken_count++;
                    end
                end
                default: advance_slot(1'b0, '0, '0, 1'b0, rt);
            endcase
        end
    endtask

    function automatic isa_pkg::word_t fetch_word(input isa_pkg::word_t addr);
        if ((addr >> 2) < PROG_LEN) begin
            return prog[addr >> 2];
        end
        return '0;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus and monitor
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        imem_data <= fetch_word(imem_addr);
    end

    always @(posedge clk) begin
        if (rst_n && wb_we) begin
            if (exp_addr_q.size() == 0) begin
                $display("Writeback to register %0d arrived with nothing left to retire",
                         wb_addr);
                stop_on_error();
            end else begin
                check_wb_addr(wb_addr, exp_addr_q.pop_front());
                check_wb_data(wb_data, exp_data_q.pop_front());
                wb_count++;
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        imem_data   = '0;
        seed        = 32'hdf7a_ebe7;
        wb_count    = 0;
        taken_count = 0;
        stall_count = 0;
        build_program();
        run_model();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_wb_we(wb_we, 1'b0);
            check_imem_addr(imem_addr, '0);
        end
        rst_n = 1'b1;
        // Nothing can retire before the fourth edge
        repeat (3) begin
            @(negedge clk);
            check_wb_we(wb_we, 1'b0);
        end
        while (imem_addr < PROG_LEN * 4) begin
            @(negedge clk);
        end
        repeat (TAIL_CYCLES) @(negedge clk);
        if (exp_addr_q.size() != 0) begin
            $display("%0d expected writebacks never came out of the pipeline",
                     exp_addr_q.size());
            stop_on_error();
        end else begin
            $display("Checked %0d writebacks, %0d taken branches, %0d load-use stalls",
                     wb_count, taken_count, stall_count);
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: mips_pipeline_top.sv
`timescale 1ns/1ps

module mips_pipeline_top #(
    parameter int DMEM_WORDS = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    output isa_pkg::word_t    imem_addr,
    input  isa_pkg::word_t    imem_data,
    output logic              wb_we,
    output isa_pkg::reg_idx_t wb_addr,
    output isa_pkg::word_t    wb_data
);

    isa_pkg::word_t     ifid_pc_plus4;
    isa_pkg::word_t     ifid_instr;
    logic               branch_taken;
    isa_pkg::word_t     branch_target;
    logic               stall;
    pipe_pkg::fwd_sel_t fwd_a;
    pipe_pkg::fwd_sel_t fwd_b;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .ifid_pc_plus4 (ifid_pc_plus4),
        .ifid_instr    (ifid_instr)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .ifid_pc_plus4 (ifid_pc_plus4),
        .ifid_instr    (ifid_instr),
        .wb_we         (wb_we),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .id_ex         (id_ex.decode)
    );

    hazard_unit u_hazard (
        .ifid_instr (ifid_instr),
        .id_ex      (id_ex.hazard),
        .ex_mem     (ex_mem.hazard),
        .wb_we      (wb_we),
        .wb_addr    (wb_addr),
        .stall      (stall),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

    execute_stage u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .id_ex   (id_ex.execute),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .wb_data (wb_data),
        .ex_mem  (ex_mem.execute)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex_mem  (ex_mem.memory),
        .wb_we   (wb_we),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

endmodule

// File: memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    ex_mem_if.memory          ex_mem,
    output logic              wb_we,
    output isa_pkg::reg_idx_t wb_addr,
    output isa_pkg::word_t    wb_data
);

    localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    isa_pkg::word_t dmem [DMEM_WORDS];
    isa_pkg::word_t word_addr;
    logic [AW-1:0]  mem_idx;
    isa_pkg::word_t load_data;

    // Byte address to word index, wrapped to the depth
    assign word_addr = ex_mem.alu_result >> 2;
    assign mem_idx   = AW'(word_addr % DMEM_WORDS);
    assign load_data = dmem[mem_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.ctrl.mem_write) begin
            dmem[mem_idx] <= ex_mem.store_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // MEM/WB register and writeback select
    ////////////////////////////////////////////////////////////
    isa_pkg::word_t wb_load;
    isa_pkg::word_t wb_alu;
    logic           wb_mem_to_reg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we         <= 1'b0;
            wb_mem_to_reg <= 1'b0;
            wb_addr       <= '0;
            wb_load       <= '0;
            wb_alu        <= '0;
        end else begin
            wb_we         <= ex_mem.ctrl.reg_write;
            wb_mem_to_reg <= ex_mem.ctrl.mem_to_reg;
            wb_addr       <= ex_mem.dest;
            wb_load       <= load_data;
            wb_alu        <= ex_mem.alu_result;
        end
    end

    assign wb_data = wb_mem_to_reg ? wb_load : wb_alu;

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk,
    input  logic               rst_n,
    id_ex_if.execute           id_ex,
    input  pipe_pkg::fwd_sel_t fwd_a,
    input  pipe_pkg::fwd_sel_t fwd_b,
    input  isa_pkg::word_t     wb_data,
    ex_mem_if.execute          ex_mem
);

    isa_pkg::word_t    opnd_a;
    isa_pkg::word_t    rt_fwd;
    isa_pkg::word_t    opnd_b;
    isa_pkg::word_t    alu_out;
    isa_pkg::reg_idx_t dest;

    ////////////////////////////////////////////////////////////
    // Operand muxes
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (fwd_a)
            pipe_pkg::FWD_EX_MEM: opnd_a = ex_mem.alu_result;
            pipe_pkg::FWD_MEM_WB: opnd_a = wb_data;
            default:              opnd_a = id_ex.rs_data;
        endcase
        case (fwd_b)
            pipe_pkg::FWD_EX_MEM: rt_fwd = ex_mem.alu_result;
            pipe_pkg::FWD_MEM_WB: rt_fwd = wb_data;
            default:              rt_fwd = id_ex.rt_data;
        endcase
    end

    assign opnd_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : rt_fwd;
    assign dest   = id_ex.ctrl.reg_dst_rd ? id_ex.dest : id_ex.rt;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            pipe_pkg::ALU_AND: alu_out = opnd_a & opnd_b;
            pipe_pkg::ALU_OR:  alu_out = opnd_a | opnd_b;
            pipe_pkg::ALU_ADD: alu_out = opnd_a + opnd_b;
            default:           alu_out = opnd_a - opnd_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem.ctrl       <= pipe_pkg::CTRL_BUBBLE;
            ex_mem.alu_result <= '0;
            ex_mem.store_data <= '0;
            ex_mem.dest       <= '0;
        end else begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= alu_out;
            ex_mem.store_data <= rt_fwd;
            ex_mem.dest       <= dest;
        end
    end

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  isa_pkg::word_t     ifid_instr,
    id_ex_if.hazard            id_ex,
    ex_mem_if.hazard           ex_mem,
    input  logic               wb_we,
    input  isa_pkg::reg_idx_t  wb_addr,
    output logic               stall,
    output pipe_pkg::fwd_sel_t fwd_a,
    output pipe_pkg::fwd_sel_t fwd_b
);

    isa_pkg::reg_idx_t id_rs;
    isa_pkg::reg_idx_t id_rt;

    assign id_rs = ifid_instr[isa_pkg::RS_MSB:isa_pkg::RS_LSB];
    assign id_rt = ifid_instr[isa_pkg::RT_MSB:isa_pkg::RT_LSB];

    // Load in EX feeding the instruction in ID
    assign stall = id_ex.ctrl.mem_read && (id_ex.rt != 5'd0) &&
                   ((id_ex.rt == id_rs) || (id_ex.rt == id_rt));

    ////////////////////////////////////////////////////////////
    // Forwarding where the youngest result wins
    ////////////////////////////////////////////////////////////
    function automatic pipe_pkg::fwd_sel_t fwd_for(isa_pkg::reg_idx_t src);
        pipe_pkg::fwd_sel_t sel;
        sel = pipe_pkg::FWD_NONE;
        if (ex_mem.ctrl.reg_write && ex_mem.dest != 5'd0 && ex_mem.dest == src) begin
            sel = pipe_pkg::FWD_EX_MEM;
        end else if (wb_we && wb_addr != 5'd0 && wb_addr == src) begin
            sel = pipe_pkg::FWD_MEM_WB;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = fwd_for(id_ex.rs);
        fwd_b = fwd_for(id_ex.rt);
    end

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  isa_pkg::word_t    ifid_pc_plus4,
    input  isa_pkg::word_t    ifid_instr,
    input  logic              wb_we,
    input  isa_pkg::reg_idx_t wb_addr,
    input  isa_pkg::word_t    wb_data,
    output logic              branch_taken,
    output isa_pkg::word_t    branch_target,
    id_ex_if.decode           id_ex
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t dest_sel;
    isa_pkg::word_t    imm;
    isa_pkg::word_t    rs_data;
    isa_pkg::word_t    rt_data;
    pipe_pkg::ctrl_t   ctrl;
    logic              is_beq;

    assign opcode = ifid_instr[isa_pkg::OP_MSB:isa_pkg::OP_LSB];
    assign funct  = ifid_instr[isa_pkg::FN_MSB:isa_pkg::FN_LSB];
    assign rs     = ifid_instr[isa_pkg::RS_MSB:isa_pkg::RS_LSB];
    assign rt     = ifid_instr[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
    assign rd     = ifid_instr[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
    assign imm    = {{16{ifid_instr[isa_pkg::IMM_MSB]}},
                     ifid_instr[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB]};

    register_file #(
        .NUM_REGS (isa_pkg::NUM_REGS)
    ) u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs),
        .rt_addr (rt),
        .wr_addr (wb_addr),
        .wr_en   (wb_we),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    ////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        ctrl   = pipe_pkg::CTRL_BUBBLE;
        is_beq = 1'b0;
        case (opcode)
            isa_pkg::OP_RTYPE: begin
                ctrl.reg_dst_rd = 1'b1;
                ctrl.reg_write  = 1'b1;
                case (funct)
                    isa_pkg::FN_ADD: ctrl.alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUB: ctrl.alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND: ctrl.alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:  ctrl.alu_op = pipe_pkg::ALU_OR;
                    // Unknown funct, incl. the zero word
                    default:         ctrl        = pipe_pkg::CTRL_BUBBLE;
                endcase
            end
            isa_pkg::OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = pipe_pkg::ALU_ADD;
            end
            isa_pkg::OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = pipe_pkg::ALU_ADD;
            end
            isa_pkg::OP_BEQ: is_beq = 1'b1;
            default:         ctrl   = pipe_pkg::CTRL_BUBBLE;
        endcase
        dest_sel = ctrl.reg_dst_rd ? rd : rt;
        if (dest_sel == 5'd0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    // A stalled beq waits and resolves next cycle
    assign branch_taken  = is_beq && (rs_data == rt_data) && !stall;
    assign branch_target = ifid_pc_plus4 + {imm[29:0], 2'b00};

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.ctrl    <= pipe_pkg::CTRL_BUBBLE;
            id_ex.rs      <= '0;
            id_ex.rt      <= '0;
            id_ex.dest    <= '0;
            id_ex.rs_data <= '0;
            id_ex.rt_data <= '0;
            id_ex.imm     <= '0;
        end else begin
            if (stall) begin
                id_ex.ctrl <= pipe_pkg::CTRL_BUBBLE;
            end else begin
                id_ex.ctrl <= ctrl;
            end
            id_ex.rs      <= rs;
            id_ex.rt      <= rt;
            id_ex.dest    <= rd;
            id_ex.rs_data <= rs_data;
            id_ex.rt_data <= rt_data;
            id_ex.imm     <= imm;
        end
    end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file #(
    parameter int NUM_REGS = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic [4:0]  wr_addr,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so WB and ID can share a cycle
    assign rs_data = (rs_addr == 5'd0)                ? 32'd0   :
                     (wr_en && wr_addr == rs_addr)    ? wr_data : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0)                ? 32'd0   :
                     (wr_en && wr_addr == rt_addr)    ? wr_data : regs[rt_addr];

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  logic           branch_taken,
    input  isa_pkg::word_t branch_target,
    output isa_pkg::word_t imem_addr,
    input  isa_pkg::word_t imem_data,
    output isa_pkg::word_t ifid_pc_plus4,
    output isa_pkg::word_t ifid_instr
);

    isa_pkg::word_t pc;
    isa_pkg::word_t pc_plus4;
    isa_pkg::word_t next_pc;

    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;
    assign next_pc   = branch_taken ? branch_target : pc_plus4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifid_pc_plus4 <= '0;
            ifid_instr    <= '0;
        end else if (stall) begin
            ifid_pc_plus4 <= ifid_pc_plus4;
            ifid_instr    <= ifid_instr;
        end else if (branch_taken) begin
            // Squash the slot fetched behind the beq
            ifid_pc_plus4 <= '0;
            ifid_instr    <= '0;
        end else begin
            ifid_pc_plus4 <= pc_plus4;
            ifid_instr    <= imem_data;
        end
    end

endmodule

// File: ex_mem_if.sv
`timescale 1ns/1ps

interface ex_mem_if;

    pipe_pkg::ctrl_t   ctrl;
    isa_pkg::word_t    alu_result;
    isa_pkg::word_t    store_data;
    isa_pkg::reg_idx_t dest;

    modport execute (output ctrl, alu_result, store_data, dest);

    modport memory (input ctrl, alu_result, store_data, dest);

    modport hazard (input ctrl, dest);

endinterface

// File: id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if;

    pipe_pkg::ctrl_t   ctrl;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    // rd field; execute picks rd or rt
    isa_pkg::reg_idx_t dest;
    isa_pkg::word_t    rs_data;
    isa_pkg::word_t    rt_data;
    isa_pkg::word_t    imm;

    modport decode (output ctrl, rs, rt, dest, rs_data, rt_data, imm);

    modport execute (input ctrl, rs, rt, dest, rs_data, rt_data, imm);

    modport hazard (input ctrl, rs, rt);

endinterface

// File: pipe_pkg.sv
package pipe_pkg;

    // Two-bit ALU operation select
    typedef enum logic [1:0] {
        ALU_AND = 2'b00,
        ALU_OR  = 2'b01,
        ALU_ADD = 2'b10,
        ALU_SUB = 2'b11
    } alu_op_t;

    // Operand source for the EX stage
    typedef enum logic [1:0] {
        FWD_NONE   = 2'b00,
        FWD_EX_MEM = 2'b01,
        FWD_MEM_WB = 2'b10
    } fwd_sel_t;

    ////////////////////////////////////////////////////////////
    // Per-instruction control carried down the pipe
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        // WB group
        logic    reg_write;
        logic    mem_to_reg;
        // MEM group
        logic    mem_read;
        logic    mem_write;
        // EX group
        logic    alu_src_imm;
        logic    reg_dst_rd;
        alu_op_t alu_op;
    } ctrl_t;

    // All zero is a bubble
    localparam ctrl_t CTRL_BUBBLE = '{
        reg_write:   1'b0,
        mem_to_reg:  1'b0,
        mem_read:    1'b0,
        mem_write:   1'b0,
        alu_src_imm: 1'b0,
        reg_dst_rd:  1'b0,
        alu_op:      ALU_AND
    };

endpackage

// File: isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int NUM_REGS = 32;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;

    // R-type function codes
    localparam logic [5:0] FN_ADD = 6'b100000;
    localparam logic [5:0] FN_SUB = 6'b100010;
    localparam logic [5:0] FN_AND = 6'b100100;
    localparam logic [5:0] FN_OR  = 6'b100101;

    ////////////////////////////////////////////////////////////
    // Instruction field positions
    ////////////////////////////////////////////////////////////
    localparam int OP_MSB  = 31;
    localparam int OP_LSB  = 26;
    localparam int RS_MSB  = 25;
    localparam int RS_LSB  = 21;
    localparam int RT_MSB  = 20;
    localparam int RT_LSB  = 16;
    localparam int RD_MSB  = 15;
    localparam int RD_LSB  = 11;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;
    localparam int FN_MSB  = 5;
    localparam int FN_LSB  = 0;

endpackage
